/* hw/valu_defs.svh */
`ifndef VALU_DEFS_SVH
`define VALU_DEFS_SVH

`define VALU_DATA_W 64
`define VALU_LANES  8    // byte slices per word
`define VALU_ADDR_W 32
`define VALU_VL_W   8
`define VALU_BE_W   8
`define VALU_FUNC_W 6

// add group, class 000
`define VALU_F_ADD  6'b000000
`define VALU_F_SUB  6'b000010

// min/max group 0001, sel[1] max, sel[0] signed
`define VALU_F_MINU 6'b000100
`define VALU_F_MIN  6'b000101
`define VALU_F_MAXU 6'b000110
`define VALU_F_MAX  6'b000111

// logic group 0010
`define VALU_F_AND  6'b001000
`define VALU_F_OR   6'b001001
`define VALU_F_XOR  6'b001010

`endif

/* hw/valu_op_pkg.sv */
`include "valu_defs.svh"

package valu_op_pkg;

    typedef enum logic [1:0] {
        e8  = 2'd0,
        e16 = 2'd1,
        e32 = 2'd2,
        e64 = 2'd3
    } sew_e;

    // class view, add/sub decode
    typedef struct packed {
        logic [2:0]              cls;
        logic [`VALU_FUNC_W-4:0] sel;
    } cls_sel_t;

    // group view, min/max and logic decode
    typedef struct packed {
        logic [3:0]              grp;
        logic [`VALU_FUNC_W-5:0] sel;
    } grp_sel_t;

    typedef union packed {
        cls_sel_t cls_sel;
        grp_sel_t grp_sel;
    } func_u;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_min,
        op_max,
        op_logic
    } op_kind_e;

    typedef enum logic [1:0] {
        l_and,
        l_or,
        l_xor
    } logic_sel_e;

    // low lane index bits that stay inside one element
    function automatic logic [2:0] sew_mask(sew_e sew);
        case (sew)
            e8:      return 3'b000;
            e16:     return 3'b001;
            e32:     return 3'b011;
            default: return 3'b111;
        endcase
    endfunction

endpackage

/* hw/valu_pipe_pkg.sv */
`include "valu_defs.svh"

package valu_pipe_pkg;

    // travels unchanged next to the data
    typedef struct packed {
        logic [`VALU_ADDR_W-1:0] addr;
        logic [`VALU_BE_W-1:0]   be;
        logic [`VALU_VL_W-1:0]   vl;
    } side_t;

    // decoded request, stage 1
    typedef struct packed {
        logic                      valid;
        valu_op_pkg::op_kind_e     kind;
        logic                      sgn;    // signed compare
        valu_op_pkg::logic_sel_e   lsel;
        valu_op_pkg::sew_e         sew;
        logic [`VALU_DATA_W-1:0]   data0;
        logic [`VALU_DATA_W-1:0]   data1;
        side_t                     side;
    } op_t;

    // per byte slice, stage 2
    typedef struct packed {
        logic [7:0] res;
        logic [7:0] d0;
        logic [7:0] d1;
        logic       lt;   // only meaningful on an element top byte
    } lane_t;

endpackage

/* hw/valu_decode.sv */
`timescale 1ns/1ps
`include "valu_defs.svh"

module valu_decode (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req_valid,
    input  valu_op_pkg::func_u             req_func_id,
    input  valu_op_pkg::sew_e              req_sew,
    input  logic [`VALU_DATA_W-1:0]        req_data0,
    input  logic [`VALU_DATA_W-1:0]        req_data1,
    input  logic [`VALU_ADDR_W-1:0]        req_addr,
    input  logic [`VALU_BE_W-1:0]          req_be,
    input  logic [`VALU_VL_W-1:0]          req_vl,
    output valu_pipe_pkg::op_t             op
);

    localparam valu_op_pkg::func_u F_ADD  = `VALU_F_ADD;
    localparam valu_op_pkg::func_u F_SUB  = `VALU_F_SUB;
    localparam valu_op_pkg::func_u F_MINU = `VALU_F_MINU;
    localparam valu_op_pkg::func_u F_AND  = `VALU_F_AND;
    localparam valu_op_pkg::func_u F_OR   = `VALU_F_OR;
    localparam valu_op_pkg::func_u F_XOR  = `VALU_F_XOR;

    valu_op_pkg::op_kind_e   kind;
    valu_op_pkg::logic_sel_e lsel;
    logic                    sgn;
    logic                    known;

    always_comb begin
        kind  = valu_op_pkg::op_add;
        lsel  = valu_op_pkg::l_and;
        sgn   = 1'b0;
        known = 1'b0;
        if (req_func_id.cls_sel.cls == F_ADD.cls_sel.cls &&
            req_func_id.cls_sel.sel == F_ADD.cls_sel.sel) begin
            known = 1'b1;
        end else if (req_func_id.cls_sel.cls == F_SUB.cls_sel.cls &&
                     req_func_id.cls_sel.sel == F_SUB.cls_sel.sel) begin
            kind  = valu_op_pkg::op_sub;
            known = 1'b1;
        end else if (req_func_id.grp_sel.grp == F_MINU.grp_sel.grp) begin
            // sel[1] picks max, sel[0] signed
            kind  = req_func_id.grp_sel.sel[1] ? valu_op_pkg::op_max : valu_op_pkg::op_min;
            sgn   = req_func_id.grp_sel.sel[0];
            known = 1'b1;
        end else if (req_func_id.grp_sel.grp == F_AND.grp_sel.grp) begin
            kind  = valu_op_pkg::op_logic;
            known = 1'b1;
            case (req_func_id.grp_sel.sel)
                F_AND.grp_sel.sel: lsel = valu_op_pkg::l_and;
                F_OR.grp_sel.sel:  lsel = valu_op_pkg::l_or;
                F_XOR.grp_sel.sel: lsel = valu_op_pkg::l_xor;
                default:           known = 1'b0;   // 0010_11 is free
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op.valid <= 1'b0;
        end else begin
            op.valid <= req_valid & known;   // unknown codes die here
        end
        op.kind  <= kind;
        op.sgn   <= sgn;
        op.lsel  <= lsel;
        op.sew   <= req_sew;
        op.data0 <= req_data0;
        op.data1 <= req_data1;
        op.side  <= '{addr: req_addr, be: req_be, vl: req_vl};
    end

endmodule

/* hw/valu_byte_slice.sv */
`timescale 1ns/1ps
`include "valu_defs.svh"

module valu_byte_slice #(
    parameter int LANE = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  valu_pipe_pkg::op_t    op,
    input  logic                  carry_in,
    output logic                  carry_out,
    output valu_pipe_pkg::lane_t  lane
);

    localparam logic [2:0] IDX = 3'(LANE);

    logic [2:0] msk;
    logic       elem_start;
    logic       elem_top;
    logic [7:0] a;
    logic [7:0] b;
    logic       inv;
    logic       cin;
    logic [7:0] sum;
    logic [7:0] lres;
    logic       lt;

    assign msk        = valu_op_pkg::sew_mask(op.sew);
    assign elem_start = (IDX & msk) == 3'b000;
    assign elem_top   = (IDX & msk) == msk;

    assign a = op.data0[8*LANE +: 8];
    assign b = op.data1[8*LANE +: 8];

    // sub and compare both run a + ~b + 1
    assign inv = op.kind != valu_op_pkg::op_add;
    assign cin = elem_start ? inv : carry_in;

    assign {carry_out, sum} = {1'b0, a} + {1'b0, inv ? ~b : b} + {8'd0, cin};

    always_comb begin
        case (op.lsel)
            valu_op_pkg::l_or:  lres = a | b;
            valu_op_pkg::l_xor: lres = a ^ b;
            default:            lres = a & b;
        endcase
    end

    always_comb begin
        lt = 1'b0;
        if (elem_top) begin
            if (op.sgn) begin
                lt = (a[7] ^ b[7]) ? a[7] : sum[7];   // signs differ, no overflow check
            end else begin
                lt = ~carry_out;   // borrow out
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lane <= '0;
        end else if (op.valid) begin
            lane.res <= (op.kind == valu_op_pkg::op_logic) ? lres : sum;
            lane.d0  <= a;
            lane.d1  <= b;
            lane.lt  <= lt;
        end
    end

endmodule

/* hw/valu_collect.sv */
`timescale 1ns/1ps
`include "valu_defs.svh"

module valu_collect (
    input  logic                     clk,
    input  logic                     rst,
    input  valu_pipe_pkg::lane_t     lanes [`VALU_LANES],
    input  valu_pipe_pkg::op_t       op,
    output logic                     resp_valid,
    output logic [`VALU_DATA_W-1:0]  resp_data,
    output logic [`VALU_ADDR_W-1:0]  resp_addr,
    output logic [`VALU_BE_W-1:0]    resp_be,
    output logic [`VALU_VL_W-1:0]    resp_vl
);

    // op fields lined up with the lane registers
    logic                    valid_q;
    valu_op_pkg::op_kind_e   kind_q;
    valu_op_pkg::sew_e       sew_q;
    valu_pipe_pkg::side_t    side_q;

    logic [2:0]              msk;
    logic                    minmax;
    logic [`VALU_LANES-1:0]  pick0;
    logic [`VALU_DATA_W-1:0] data_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= op.valid;
        end
        kind_q <= op.kind;
        sew_q  <= op.sew;
        side_q <= op.side;
    end

    assign msk    = valu_op_pkg::sew_mask(sew_q);
    assign minmax = kind_q == valu_op_pkg::op_min || kind_q == valu_op_pkg::op_max;

    always_comb begin
        for (int i = 0; i < `VALU_LANES; i++) begin
            // flag lives on the element's top byte
            pick0[i] = (kind_q == valu_op_pkg::op_min) ?
                       lanes[3'(i) | msk].lt : ~lanes[3'(i) | msk].lt;
            if (minmax) begin
                data_next[8*i +: 8] = pick0[i] ? lanes[i].d0 : lanes[i].d1;
            end else begin
                data_next[8*i +: 8] = lanes[i].res;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= valid_q;
        end
        resp_data <= data_next;
        resp_addr <= side_q.addr;
        resp_be   <= side_q.be;
        resp_vl   <= side_q.vl;
    end

endmodule

/* hw/valu_top.sv */
`timescale 1ns/1ps
`include "valu_defs.svh"

module valu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  valu_op_pkg::func_u       req_func_id,
    input  valu_op_pkg::sew_e        req_sew,
    input  logic [`VALU_DATA_W-1:0]  req_data0,
    input  logic [`VALU_DATA_W-1:0]  req_data1,
    input  logic [`VALU_ADDR_W-1:0]  req_addr,
    input  logic [`VALU_BE_W-1:0]    req_be,
    input  logic [`VALU_VL_W-1:0]    req_vl,
    output logic                     resp_valid,
    output logic [`VALU_DATA_W-1:0]  resp_data,
    output logic [`VALU_ADDR_W-1:0]  resp_addr,
    output logic [`VALU_BE_W-1:0]    resp_be,
    output logic [`VALU_VL_W-1:0]    resp_vl
);

    valu_pipe_pkg::op_t    op;
    valu_pipe_pkg::lane_t  lanes [`VALU_LANES];
    logic [`VALU_LANES-1:0] carry;      // carry out of each slice
    logic [`VALU_LANES-1:0] carry_in;

    assign carry_in = {carry[`VALU_LANES-2:0], 1'b0};   // lane 0 always starts an element

    valu_decode i_decode (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_func_id (req_func_id),
        .req_sew     (req_sew),
        .req_data0   (req_data0),
        .req_data1   (req_data1),
        .req_addr    (req_addr),
        .req_be      (req_be),
        .req_vl      (req_vl),
        .op          (op)
    );

    for (genvar i = 0; i < `VALU_LANES; i++) begin : g_slice
        valu_byte_slice #(
            .LANE (i)
        ) i_slice (
            .clk       (clk),
            .rst       (rst),
            .op        (op),
            .carry_in  (carry_in[i]),
            .carry_out (carry[i]),
            .lane      (lanes[i])
        );
    end

    valu_collect i_collect (
        .clk        (clk),
        .rst        (rst),
        .lanes      (lanes),
        .op         (op),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_addr  (resp_addr),
        .resp_be    (resp_be),
        .resp_vl    (resp_vl)
    );

endmodule

/* tests/valu_properties.sv */
`timescale 1ns/1ps
`include "valu_defs.svh"

module valu_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    req_valid,
    input logic [`VALU_FUNC_W-1:0] req_func_id,
    input logic                    resp_valid
);

    logic known;

    assign known = req_func_id inside {`VALU_F_ADD, `VALU_F_SUB, `VALU_F_MINU, `VALU_F_MIN,
        `VALU_F_MAXU, `VALU_F_MAX, `VALU_F_AND, `VALU_F_OR, `VALU_F_XOR};

    // nothing leaks out of reset
    a_reset_quiet : assert property (@(posedge clk) rst |=> !resp_valid)
        else $error("resp_valid high after a reset cycle");

    a_latency : assert property (@(posedge clk) disable iff (rst)
        req_valid && known |-> ##3 resp_valid)
        else $error("known request without resp_valid three cycles later");

    // three stages, so the request sits three edges back
    a_no_orphan : assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> $past(req_valid && known, 3))
        else $error("resp_valid without a matching request");

endmodule

bind valu_top valu_properties i_props (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req_func_id (req_func_id),
    .resp_valid  (resp_valid)
);

/* tests/valu_tb.sv */
`timescale 1ns/1ps
`include "valu_defs.svh"

module valu_tb;

    typedef struct packed {
        logic [`VALU_DATA_W-1:0] data;
        logic [`VALU_ADDR_W-1:0] addr;
        logic [`VALU_BE_W-1:0]   be;
        logic [`VALU_VL_W-1:0]   vl;
        logic [31:0]             cyc;   // cycle the request was driven
    } exp_t;

    localparam logic [5:0] CODES [9] = '{`VALU_F_ADD, `VALU_F_SUB, `VALU_F_MINU, `VALU_F_MIN,
        `VALU_F_MAXU, `VALU_F_MAX, `VALU_F_AND, `VALU_F_OR, `VALU_F_XOR};
    localparam logic [5:0] BAD [4] = '{6'b000001, 6'b001011, 6'b010000, 6'b111111};

    logic                    clk;
    logic                    rst;
    logic                    req_valid;
    valu_op_pkg::func_u      req_func_id;
    valu_op_pkg::sew_e       req_sew;
    logic [`VALU_DATA_W-1:0] req_data0;
    logic [`VALU_DATA_W-1:0] req_data1;
    logic [`VALU_ADDR_W-1:0] req_addr;
    logic [`VALU_BE_W-1:0]   req_be;
    logic [`VALU_VL_W-1:0]   req_vl;
    logic                    resp_valid;
    logic [`VALU_DATA_W-1:0] resp_data;
    logic [`VALU_ADDR_W-1:0] resp_addr;
    logic [`VALU_BE_W-1:0]   resp_be;
    logic [`VALU_VL_W-1:0]   resp_vl;

    exp_t        exp_q[$];
    logic [31:0] cyc = '0;
    integer      seed;
    int          n_checks;
    int          n_errors;
    int          n_tests;

    valu_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_func_id (req_func_id),
        .req_sew     (req_sew),
        .req_data0   (req_data0),
        .req_data1   (req_data1),
        .req_addr    (req_addr),
        .req_be      (req_be),
        .req_vl      (req_vl),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_addr   (resp_addr),
        .resp_be     (resp_be),
        .resp_vl     (resp_vl)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("[FAIL] %0d ns %s got %h expected %h", $time, name, got, want);
        end
    endtask

    function automatic logic code_known(input logic [5:0] f);
        return f inside {`VALU_F_ADD, `VALU_F_SUB, `VALU_F_MINU, `VALU_F_MIN, `VALU_F_MAXU,
                         `VALU_F_MAX, `VALU_F_AND, `VALU_F_OR, `VALU_F_XOR};
    endfunction

    // reference model works one element at a time
    function automatic logic [63:0] model(input logic [5:0] f, input logic [1:0] sew,
                                          input logic [63:0] d0, input logic [63:0] d1);
        int          w;
        logic [63:0] m;
        logic [63:0] sb;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic [63:0] res;
        logic        lt_u;
        logic        lt_s;
        w   = 8 << sew;
        m   = (w == 64) ? '1 : ((64'd1 << w) - 1);
        sb  = 64'd1 << (w - 1);
        res = '0;
        for (int i = 0; i < 64 / w; i++) begin
            a    = (d0 >> (i * w)) & m;
            b    = (d1 >> (i * w)) & m;
            lt_u = a < b;
            lt_s = (a ^ sb) < (b ^ sb);   // flipping the sign bit orders signed values
            case (f)
                `VALU_F_ADD:  r = a + b;
                `VALU_F_SUB:  r = a - b;
                `VALU_F_MINU: r = lt_u ? a : b;
                `VALU_F_MIN:  r = lt_s ? a : b;
                `VALU_F_MAXU: r = lt_u ? b : a;
                `VALU_F_MAX:  r = lt_s ? b : a;
                `VALU_F_AND:  r = a & b;
                `VALU_F_OR:   r = a | b;
                default:      r = a ^ b;
            endcase
            res = res | ((r & m) << (i * w));
        end
        return res;
    endfunction

    function automatic logic [63:0] splat(input logic [1:0] sew, input logic [63:0] v);
        logic [63:0] r;
        int          w;
        w = 8 << sew;
        r = '0;
        for (int i = 0; i < 64 / w; i++) begin
            r = r | (v << (i * w));
        end
        return r;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // drives one request for one cycle and queues its expected response
    task automatic send(input logic [5:0] f, input logic [1:0] sew,
                        input logic [63:0] d0, input logic [63:0] d1);
        exp_t e;
        e.addr = $random(seed);
        e.be   = $random(seed);
        e.vl   = $random(seed);
        @(posedge clk);
        #2;
        req_valid   = 1'b1;
        req_func_id = f;
        req_sew     = valu_op_pkg::sew_e'(sew);
        req_data0   = d0;
        req_data1   = d1;
        req_addr    = e.addr;
        req_be      = e.be;
        req_vl      = e.vl;
        if (code_known(f)) begin
            e.data = model(f, sew, d0, d1);
            e.cyc  = cyc;
            exp_q.push_back(e);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            req_valid = 1'b0;
        end
    endtask

    task automatic settle();
        int i;
        idle(1);
        i = 0;
        while (exp_q.size() != 0 && i < 50) begin
            @(posedge clk);
            i++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout at %0d ns: %0d responses never arrived", $time, exp_q.size());
            n_errors++;
            exp_q.delete();
        end
        idle(4);   // room for a stray response
    endtask

    task automatic finish_test(input string name, input int err0);
        n_tests++;
        $display("test %-10s finished, %0d errors", name, n_errors - err0);
    endtask

    always @(negedge clk) begin
        exp_t e;
        if (!rst && resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected response at %0d ns with no request outstanding", $time);
                n_errors++;
            end else begin
                e = exp_q.pop_front();
                check("resp_data", resp_data, e.data);
                check("resp_addr", resp_addr, e.addr);
                check("resp_be", resp_be, e.be);
                check("resp_vl", resp_vl, e.vl);
                check("latency", cyc - e.cyc, 3);
            end
        end
    end

    task automatic test_reset_idle();
        int err0;
        err0 = n_errors;
        repeat (10) begin
            @(negedge clk);
            check("resp_valid", resp_valid, 0);
        end
        send(`VALU_F_ADD, 0, rand64(), rand64());
        settle();
        finish_test("reset_idle", err0);
    endtask

    task automatic test_add_sub();
        int          err0;
        logic [63:0] top;
        err0 = n_errors;
        for (int s = 0; s < 4; s++) begin
            top = 64'd1 << ((8 << s) - 1);
            for (int k = 0; k < 4; k++) begin
                send(`VALU_F_ADD, s, rand64(), rand64());
                send(`VALU_F_SUB, s, rand64(), rand64());
            end
            send(`VALU_F_ADD, s, '1, splat(s, 1));   // carry out of every element
            send(`VALU_F_SUB, s, '0, splat(s, 1));   // borrow everywhere
            send(`VALU_F_ADD, s, splat(s, top), splat(s, top));   // top bits overflow
        end
        settle();
        finish_test("add_sub", err0);
    endtask

    task automatic test_min_max();
        int          err0;
        logic [63:0] top;
        err0 = n_errors;
        for (int s = 0; s < 4; s++) begin
            top = 64'd1 << ((8 << s) - 1);
            for (int c = 2; c < 6; c++) begin
                send(CODES[c], s, rand64(), rand64());
                send(CODES[c], s, rand64(), rand64());
                // signed and unsigned order disagree
                send(CODES[c], s, splat(s, top), splat(s, 1));
                send(CODES[c], s, splat(s, 1), splat(s, top));
                send(CODES[c], s, splat(s, top), splat(s, top));
            end
        end
        settle();
        finish_test("min_max", err0);
    endtask

    task automatic test_logic();
        int err0;
        err0 = n_errors;
        for (int c = 6; c < 9; c++) begin
            repeat (6) send(CODES[c], $random(seed), rand64(), rand64());
        end
        settle();
        finish_test("logic", err0);
    endtask

    task automatic test_side_burst();
        int err0;
        int c;
        err0 = n_errors;
        repeat (20) begin
            c = ($random(seed) & 32'h7fff_ffff) % 9;
            send(CODES[c], $random(seed), rand64(), rand64());
        end
        settle();
        finish_test("side_burst", err0);
    endtask

    task automatic test_unknown();
        int err0;
        err0 = n_errors;
        for (int k = 0; k < 4; k++) begin
            send(CODES[k], $random(seed), rand64(), rand64());
            send(BAD[k], $random(seed), rand64(), rand64());
            send(CODES[k + 4], $random(seed), rand64(), rand64());
        end
        send(BAD[3], 0, rand64(), rand64());   // nothing may follow the last request
        settle();
        finish_test("unknown", err0);
    endtask

    initial begin
        seed        = 94437;
        n_checks    = 0;
        n_errors    = 0;
        n_tests     = 0;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_func_id = '0;
        req_sew     = valu_op_pkg::e8;
        req_data0   = '0;
        req_data1   = '0;
        req_addr    = '0;
        req_be      = '0;
        req_vl      = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset_idle();
        test_add_sub();
        test_min_max();
        test_logic();
        test_side_burst();
        test_unknown();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+hw
hw/valu_op_pkg.sv
hw/valu_pipe_pkg.sv
hw/valu_decode.sv
hw/valu_byte_slice.sv
hw/valu_collect.sv
hw/valu_top.sv
tests/valu_properties.sv
tests/valu_tb.sv

/* Bender.yml */
package:
  name: valu

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/valu_op_pkg.sv
      - hw/valu_pipe_pkg.sv
      - hw/valu_decode.sv
      - hw/valu_byte_slice.sv
      - hw/valu_collect.sv
      - hw/valu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/valu_properties.sv
      - tests/valu_tb.sv
